//--- common/mul_pkg.sv
// Multiply unit widths, opcode enumeration and sequencer state enumeration

package mul_pkg;

        //////////////////////////////////////////////////
        // Widths
        //////////////////////////////////////////////////

        // Register width
        localparam int WORD_W = 32;

        // Half of a register
        localparam int HALF_W = 16;

        // Operand half with room for a sign bit
        localparam int PART_W = HALF_W + 1;

        // Product of two operand halves
        localparam int PROD_W = 2 * PART_W;

        // Long accumulator
        localparam int ACC_W  = 2 * WORD_W;

        //////////////////////////////////////////////////
        // Opcodes
        //////////////////////////////////////////////////

        // Halfword forms: first digit picks the rm half, second the rs half
        typedef enum logic [3:0] {
                OP_NONE   = 4'd0,
                OP_UMLALL = 4'd1,
                OP_UMLALH = 4'd2,
                OP_SMLALL = 4'd3,
                OP_SMLALH = 4'd4,
                OP_SMUL00 = 4'd5,
                OP_SMUL01 = 4'd6,
                OP_SMUL10 = 4'd7,
                OP_SMUL11 = 4'd8,
                OP_SMLA00 = 4'd9,
                OP_SMLA01 = 4'd10,
                OP_SMLA10 = 4'd11,
                OP_SMLA11 = 4'd12
        } mul_op_t;

        //////////////////////////////////////////////////
        // Sequencer states
        //////////////////////////////////////////////////

        typedef enum logic [2:0] {
                ST_IDLE     = 3'd0,
                ST_PREP     = 3'd1,
                ST_SUM_LO   = 3'd2,
                ST_SUM_HI   = 3'd3,
                ST_DONE     = 3'd4,
                ST_DONE_SAT = 3'd5
        } mul_state_t;

endpackage

//--- common/mul_operand_if.sv
// Operand half interface between operand select and partial products
`timescale 1ns/1ps

interface mul_operand_if import mul_pkg::*; ();

        // Upper and lower halves of rm
        logic signed [PART_W-1:0] op_a;
        logic signed [PART_W-1:0] op_c;

        // Upper and lower halves of rs
        logic signed [PART_W-1:0] op_b;
        logic signed [PART_W-1:0] op_d;

        modport src (
                output op_a, op_b, op_c, op_d
        );

        modport dst (
                input  op_a, op_b, op_c, op_d
        );

endinterface

//--- common/mul_product_if.sv
// Partial product interface between the multipliers and the sequencer
`timescale 1ns/1ps

interface mul_product_if import mul_pkg::*; ();

        // Upper x upper, cross terms, lower x lower
        logic signed [PROD_W-1:0] prod_ab;
        logic signed [PROD_W-1:0] prod_bc;
        logic signed [PROD_W-1:0] prod_ad;
        logic signed [PROD_W-1:0] prod_cd;

        modport src (
                output prod_ab, prod_bc, prod_ad, prod_cd
        );

        modport dst (
                input  prod_ab, prod_bc, prod_ad, prod_cd
        );

endinterface

//--- design/mul_operand_select.sv
// Operand split into registered 17-bit halves with sign or zero extension
`timescale 1ns/1ps

module mul_operand_select import mul_pkg::*;
(
        input  logic              i_clk,
        input  mul_op_t           i_op,
        input  logic [WORD_W-1:0] i_rm,
        input  logic [WORD_W-1:0] i_rs,
        mul_operand_if.src        o_opnd
);

        // Halves chosen for the halfword forms
        logic [HALF_W-1:0] rm_sel;
        logic [HALF_W-1:0] rs_sel;

        //////////////////////////////////////////////////
        // Halfword selection
        //////////////////////////////////////////////////

        always_comb
        begin
                // First digit of the opcode picks the rm half
                if (i_op inside {OP_SMUL10, OP_SMUL11, OP_SMLA10, OP_SMLA11})
                begin
                        rm_sel = i_rm[WORD_W-1:HALF_W];
                end
                else
                begin
                        rm_sel = i_rm[HALF_W-1:0];
                end

                // Second digit picks the rs half
                if (i_op inside {OP_SMUL01, OP_SMUL11, OP_SMLA01, OP_SMLA11})
                begin
                        rs_sel = i_rs[WORD_W-1:HALF_W];
                end
                else
                begin
                        rs_sel = i_rs[HALF_W-1:0];
                end
        end

        //////////////////////////////////////////////////
        // Registered halves, {a,c} = rm and {b,d} = rs
        //////////////////////////////////////////////////

        always_ff @(posedge i_clk)
        begin
                case (i_op)
                        OP_UMLALL, OP_UMLALH:
                        begin
                                o_opnd.op_a <= {1'b0, i_rm[WORD_W-1:HALF_W]};
                                o_opnd.op_c <= {1'b0, i_rm[HALF_W-1:0]};
                                o_opnd.op_b <= {1'b0, i_rs[WORD_W-1:HALF_W]};
                                o_opnd.op_d <= {1'b0, i_rs[HALF_W-1:0]};
                        end
                        OP_SMLALL, OP_SMLALH:
                        begin
                                o_opnd.op_a <= {i_rm[WORD_W-1], i_rm[WORD_W-1:HALF_W]};
                                o_opnd.op_c <= {1'b0, i_rm[HALF_W-1:0]};
                                o_opnd.op_b <= {i_rs[WORD_W-1], i_rs[WORD_W-1:HALF_W]};
                                o_opnd.op_d <= {1'b0, i_rs[HALF_W-1:0]};
                        end
                        default:
                        begin
                                // Selected half becomes a sign-extended 32-bit value
                                o_opnd.op_a <= {PART_W{rm_sel[HALF_W-1]}};
                                o_opnd.op_c <= {1'b0, rm_sel};
                                o_opnd.op_b <= {PART_W{rs_sel[HALF_W-1]}};
                                o_opnd.op_d <= {1'b0, rs_sel};
                        end
                endcase
        end

endmodule

//--- design/mul_partial_products.sv
// Four registered 17x17 signed partial product multipliers
`timescale 1ns/1ps

module mul_partial_products import mul_pkg::*;
(
        input  logic       i_clk,
        mul_operand_if.dst i_opnd,
        mul_product_if.src o_prod
);

        //////////////////////////////////////////////////
        // Products, one DSP block each
        //////////////////////////////////////////////////

        // rm x rs = (a.2^16 + c) x (b.2^16 + d)
        always_ff @(posedge i_clk)
        begin
                // Upper x upper, weight 2^32
                o_prod.prod_ab <= i_opnd.op_a * i_opnd.op_b;

                // Cross terms, weight 2^16
                o_prod.prod_bc <= i_opnd.op_b * i_opnd.op_c;
                o_prod.prod_ad <= i_opnd.op_a * i_opnd.op_d;

                // Lower x lower, always non-negative
                o_prod.prod_cd <= i_opnd.op_c * i_opnd.op_d;
        end

endmodule

//--- design/mul_sequencer.sv
// Multiply-accumulate state machine with result, saturation, busy and non-zero flags
`timescale 1ns/1ps

module mul_sequencer import mul_pkg::*;
(
        input  logic              i_clk,
        input  logic              i_reset,
        input  logic              i_stall,
        input  logic              i_flush,
        input  mul_op_t           i_op,
        input  logic [WORD_W-1:0] i_rn,
        input  logic [WORD_W-1:0] i_rh,
        mul_product_if.dst        i_prod,
        output logic [WORD_W-1:0] o_rd,
        output logic              o_sat,
        output logic              o_busy,
        output logic              o_nozero
);

        // Sign extension of a partial product to accumulator width
        function automatic logic [ACC_W-1:0] sext_prod(input logic [PROD_W-1:0] prod);
                return {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod};
        endfunction

        mul_state_t        state_q;
        mul_state_t        state_nxt;
        logic [ACC_W-1:0]  acc_q;
        logic [ACC_W-1:0]  acc_nxt;
        logic              nozero_q;
        logic              nozero_nxt;
        logic              upper;
        logic              smla;
        logic [ACC_W-1:0]  ext_ab;
        logic [ACC_W-1:0]  ext_bc;
        logic [ACC_W-1:0]  ext_ad;
        logic [ACC_W-1:0]  ext_cd;

        //////////////////////////////////////////////////
        // Opcode decode and product extension
        //////////////////////////////////////////////////

        always_comb
        begin
                upper  = (i_op == OP_UMLALH) || (i_op == OP_SMLALH);
                smla   = i_op inside {OP_SMLA00, OP_SMLA01, OP_SMLA10, OP_SMLA11};
                ext_ab = sext_prod(i_prod.prod_ab);
                ext_bc = sext_prod(i_prod.prod_bc);
                ext_ad = sext_prod(i_prod.prod_ad);
                ext_cd = sext_prod(i_prod.prod_cd);
        end

        //////////////////////////////////////////////////
        // Next state and outputs
        //////////////////////////////////////////////////

        always_comb
        begin
                state_nxt  = state_q;
                acc_nxt    = acc_q;
                nozero_nxt = nozero_q;
                o_rd       = '0;
                o_sat      = 1'b0;
                o_busy     = 1'b1;
                o_nozero   = 1'b0;

                case (state_q)
                        ST_IDLE:
                        begin
                                if (i_op != OP_NONE)
                                begin
                                        state_nxt = ST_PREP;
                                end
                                else
                                begin
                                        o_busy = 1'b0;
                                end
                        end
                        ST_PREP:
                        begin
                                // Upper word reuses the sum left by its lower word
                                state_nxt = upper ? ST_DONE : ST_SUM_LO;
                        end
                        ST_SUM_LO:
                        begin
                                acc_nxt   = ext_cd + (ext_bc << HALF_W) + (ext_ad << HALF_W);
                                state_nxt = ST_SUM_HI;
                        end
                        ST_SUM_HI:
                        begin
                                acc_nxt = acc_q + (ext_ab << WORD_W) + {i_rh, i_rn};

                                // 32-bit signed overflow of product plus rn
                                if (smla && (acc_nxt[WORD_W-1] != acc_q[WORD_W-1]) &&
                                    (acc_q[WORD_W-1] == i_rn[WORD_W-1]))
                                begin
                                        state_nxt = ST_DONE_SAT;
                                end
                                else
                                begin
                                        state_nxt = ST_DONE;
                                end
                        end
                        ST_DONE, ST_DONE_SAT:
                        begin
                                state_nxt = ST_IDLE;
                                o_busy    = 1'b0;
                                o_sat     = (state_q == ST_DONE_SAT);
                                if (upper)
                                begin
                                        o_rd     = acc_q[ACC_W-1:WORD_W];
                                        o_nozero = nozero_q;
                                end
                                else
                                begin
                                        o_rd       = acc_q[WORD_W-1:0];
                                        nozero_nxt = |acc_q[WORD_W-1:0];
                                end
                        end
                        default:
                        begin
                                state_nxt = ST_IDLE;
                        end
                endcase
        end

        //////////////////////////////////////////////////
        // State registers
        //////////////////////////////////////////////////

        // Flush wins over stall
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_q  <= ST_IDLE;
                        nozero_q <= 1'b0;
                end
                else if (i_flush)
                begin
                        state_q  <= ST_IDLE;
                        nozero_q <= 1'b0;
                end
                else if (!i_stall)
                begin
                        state_q  <= state_nxt;
                        nozero_q <= nozero_nxt;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                begin
                        acc_q <= acc_nxt;
                end
        end

endmodule

//--- design/mul_unit_top.sv
// Multiply-accumulate unit top level connecting operand select, multipliers and sequencer
`timescale 1ns/1ps

module mul_unit_top import mul_pkg::*;
(
        input  logic              i_clk,
        input  logic              i_reset,
        input  logic              i_stall,
        input  logic              i_flush,
        input  mul_op_t           i_op,
        input  logic [WORD_W-1:0] i_rm,
        input  logic [WORD_W-1:0] i_rs,
        input  logic [WORD_W-1:0] i_rn,
        input  logic [WORD_W-1:0] i_rh,
        output logic [WORD_W-1:0] o_rd,
        output logic              o_sat,
        output logic              o_busy,
        output logic              o_nozero
);

        //////////////////////////////////////////////////
        // Internal buses
        //////////////////////////////////////////////////

        mul_operand_if u_opnd_bus ();
        mul_product_if u_prod_bus ();

        //////////////////////////////////////////////////
        // Datapath
        //////////////////////////////////////////////////

        // Stage 1, operand halves
        mul_operand_select u_operand_select (
                .i_clk  (i_clk),
                .i_op   (i_op),
                .i_rm   (i_rm),
                .i_rs   (i_rs),
                .o_opnd (u_opnd_bus.src)
        );

        // Stage 2, partial products
        mul_partial_products u_partial_products (
                .i_clk  (i_clk),
                .i_opnd (u_opnd_bus.dst),
                .o_prod (u_prod_bus.src)
        );

        //////////////////////////////////////////////////
        // Control and accumulation
        //////////////////////////////////////////////////

        mul_sequencer u_sequencer (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_stall  (i_stall),
                .i_flush  (i_flush),
                .i_op     (i_op),
                .i_rn     (i_rn),
                .i_rh     (i_rh),
                .i_prod   (u_prod_bus.dst),
                .o_rd     (o_rd),
                .o_sat    (o_sat),
                .o_busy   (o_busy),
                .o_nozero (o_nozero)
        );

endmodule

//--- verif/tb_mul_unit.sv
// Testbench for the multiply-accumulate unit with seeded random stimulus and a reference model
`timescale 1ns/1ps

module tb_mul_unit import mul_pkg::*; ();

        localparam logic [31:0] SEED      = 32'hae8b_f6c6;
        localparam int          TIMEOUT   = 20;
        localparam int          MAX_STALL = 4;
        localparam int          N_RANDOM  = 200;

        logic              i_clk;
        logic              i_reset;
        logic              i_stall;
        logic              i_flush;
        mul_op_t           i_op;
        logic [WORD_W-1:0] i_rm;
        logic [WORD_W-1:0] i_rs;
        logic [WORD_W-1:0] i_rn;
        logic [WORD_W-1:0] i_rh;
        logic [WORD_W-1:0] o_rd;
        logic              o_sat;
        logic              o_busy;
        logic              o_nozero;

        int n_checks;
        int n_value_err;
        int n_timeout;

        mul_op_t hw_ops [8] = '{OP_SMUL00, OP_SMUL01, OP_SMUL10, OP_SMUL11,
                                OP_SMLA00, OP_SMLA01, OP_SMLA10, OP_SMLA11};

        mul_unit_top i_dut (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_stall  (i_stall),
                .i_flush  (i_flush),
                .i_op     (i_op),
                .i_rm     (i_rm),
                .i_rs     (i_rs),
                .i_rn     (i_rn),
                .i_rh     (i_rh),
                .o_rd     (o_rd),
                .o_sat    (o_sat),
                .o_busy   (o_busy),
                .o_nozero (o_nozero)
        );

        always #10 i_clk = ~i_clk;

        //////////////////////////////////////////////////
        // Reference model
        //////////////////////////////////////////////////

        // Full 64-bit rm * rs + {rh, rn}, halfword forms use the selected halves
        function automatic logic [63:0] model_mac(input mul_op_t op, input logic [31:0] rm,
                input logic [31:0] rs, input logic [31:0] rn, input logic [31:0] rh);
                logic [63:0] x;
                logic [63:0] y;
                logic [15:0] hm;
                logic [15:0] hs;
                hm = (op inside {OP_SMUL10, OP_SMUL11, OP_SMLA10, OP_SMLA11}) ? rm[31:16] : rm[15:0];
                hs = (op inside {OP_SMUL01, OP_SMUL11, OP_SMLA01, OP_SMLA11}) ? rs[31:16] : rs[15:0];
                case (op)
                        OP_UMLALL, OP_UMLALH:
                        begin
                                x = {32'd0, rm};
                                y = {32'd0, rs};
                        end
                        OP_SMLALL, OP_SMLALH:
                        begin
                                x = {{32{rm[31]}}, rm};
                                y = {{32{rs[31]}}, rs};
                        end
                        default:
                        begin
                                x = {{48{hm[15]}}, hm};
                                y = {{48{hs[15]}}, hs};
                        end
                endcase
                return x * y + {rh, rn};
        endfunction

        // Signed 32-bit overflow of product plus rn, SMLA only
        function automatic logic model_sat(input mul_op_t op, input logic [31:0] rm,
                input logic [31:0] rs, input logic [31:0] rn);
                logic [63:0] prod;
                logic [32:0] sum;
                prod = model_mac(op, rm, rs, 32'd0, 32'd0);
                sum  = {prod[31], prod[31:0]} + {rn[31], rn};
                return (op inside {OP_SMLA00, OP_SMLA01, OP_SMLA10, OP_SMLA11}) &&
                       (sum[32] != sum[31]);
        endfunction

        //////////////////////////////////////////////////
        // Stimulus and checks
        //////////////////////////////////////////////////

        task automatic report_mismatch(input string what, input logic [31:0] got,
                input logic [31:0] exp, input mul_op_t op);
                $display("Error at %0t ns: %s is %h, expected %h for %s", $time, what, got, exp,
                         op.name());
                n_value_err++;
        endtask

        // Entered and left 2 ns after a rising edge
        task automatic run_op(input mul_op_t op, input logic [31:0] rm, input logic [31:0] rs,
                input logic [31:0] rn, input logic [31:0] rh, input bit use_stall,
                input bit exp_nozero);
                logic [63:0] full;
                logic [31:0] exp_rd;
                logic        exp_sat;
                bit          upper;
                bit          done;
                int          cycles;
                int          stalls;
                full    = model_mac(op, rm, rs, rn, rh);
                upper   = (op == OP_UMLALH) || (op == OP_SMLALH);
                exp_rd  = upper ? full[63:32] : full[31:0];
                exp_sat = model_sat(op, rm, rs, rn);
                done    = 1'b0;
                cycles  = 0;
                stalls  = 0;
                i_op    = op;
                i_rm    = rm;
                i_rs    = rs;
                i_rn    = rn;
                i_rh    = rh;
                i_stall = use_stall && ($urandom_range(3) == 0);
                while (!done && cycles < TIMEOUT)
                begin
                        @(negedge i_clk);
                        cycles++;
                        if (!o_busy)
                        begin
                                done = 1'b1;
                        end
                        else
                        begin
                                // Each stalled busy cycle delays the result by one
                                if (i_stall)
                                begin
                                        stalls++;
                                end
                                @(posedge i_clk);
                                #2;
                                i_stall = use_stall && (stalls < MAX_STALL) &&
                                          ($urandom_range(3) == 0);
                        end
                end
                if (!done)
                begin
                        $display("Timeout at %0t ns: o_busy did not fall within %0d cycles for %s",
                                 $time, TIMEOUT, op.name());
                        n_timeout++;
                end
                else
                begin
                        n_checks++;
                        if (cycles != (upper ? 3 : 5) + stalls)
                        begin
                                report_mismatch("latency", cycles, (upper ? 3 : 5) + stalls, op);
                        end
                        if (o_rd !== exp_rd)
                        begin
                                report_mismatch("o_rd", o_rd, exp_rd, op);
                        end
                        if (o_sat !== exp_sat)
                        begin
                                report_mismatch("o_sat", o_sat, exp_sat, op);
                        end
                        if (o_nozero !== (upper && exp_nozero))
                        begin
                                report_mismatch("o_nozero", o_nozero, upper && exp_nozero, op);
                        end
                end
                // A stalled result cycle repeats, so hold the opcode one more edge
                if (i_stall)
                begin
                        @(posedge i_clk);
                        #2;
                        i_stall = 1'b0;
                end
                @(posedge i_clk);
                #2;
        endtask

        task automatic run_pair(input bit signed_op, input logic [31:0] rm, input logic [31:0] rs,
                input logic [31:0] rn, input logic [31:0] rh, input bit use_stall);
                logic [63:0] full;
                mul_op_t     lo;
                mul_op_t     hi;
                lo   = signed_op ? OP_SMLALL : OP_UMLALL;
                hi   = signed_op ? OP_SMLALH : OP_UMLALH;
                full = model_mac(lo, rm, rs, rn, rh);
                run_op(lo, rm, rs, rn, rh, use_stall, 1'b0);
                run_op(hi, rm, rs, rn, rh, use_stall, |full[31:0]);
        endtask

        //////////////////////////////////////////////////
        // Main sequence
        //////////////////////////////////////////////////

        initial
        begin
                void'($urandom(SEED));
                n_checks    = 0;
                n_value_err = 0;
                n_timeout   = 0;
                i_clk       = 1'b0;
                i_reset     = 1'b1;
                i_stall     = 1'b0;
                i_flush     = 1'b0;
                i_op        = OP_NONE;
                i_rm        = '0;
                i_rs        = '0;
                i_rn        = '0;
                i_rh        = '0;
                repeat (10) @(posedge i_clk);
                #2;
                i_reset = 1'b0;
                @(negedge i_clk);
                if (o_busy !== 1'b0 || o_sat !== 1'b0 || o_nozero !== 1'b0 || o_rd !== '0)
                begin
                        $display("Error at %0t ns: outputs after reset busy=%b sat=%b nozero=%b rd=%h",
                                 $time, o_busy, o_sat, o_nozero, o_rd);
                        n_value_err++;
                end

                // Flush in the middle of a lower-word operation
                @(posedge i_clk);
                #2;
                i_op = OP_UMLALL;
                i_rm = $urandom();
                i_rs = $urandom();
                repeat (2) @(posedge i_clk);
                #2;
                i_op    = OP_NONE;
                i_flush = 1'b1;
                @(posedge i_clk);
                #2;
                i_flush = 1'b0;
                @(negedge i_clk);
                if (o_busy !== 1'b0)
                begin
                        $display("Error at %0t ns: o_busy is %b one cycle after flush", $time, o_busy);
                        n_value_err++;
                end
                @(posedge i_clk);
                #2;
                run_pair(1'b0, $urandom(), $urandom(), $urandom(), $urandom(), 1'b0);

                // Unsigned and signed long pairs, then halfword forms
                repeat (N_RANDOM) run_pair(1'b0, $urandom(), $urandom(), $urandom(), $urandom(), 1'b0);
                repeat (N_RANDOM) run_pair(1'b1, $urandom(), $urandom(), $urandom(), $urandom(), 1'b0);
                repeat (N_RANDOM) run_op(hw_ops[$urandom_range(7)], $urandom(), $urandom(),
                                         $urandom(), $urandom(), 1'b0, 1'b0);

                // Zero low words for the non-zero flag
                run_pair(1'b0, 32'd0, 32'd0, 32'd0, $urandom(), 1'b0);
                run_pair(1'b0, 32'd1, 32'd1, 32'hffff_ffff, 32'h0000_0005, 1'b0);
                run_pair(1'b1, 32'hffff_ffff, 32'd1, 32'd1, 32'd0, 1'b0);
                run_pair(1'b1, 32'h0001_0000, 32'h0001_0000, 32'd0, 32'd0, 1'b0);

                // Mixed operations under random stall pulses
                repeat (N_RANDOM)
                begin
                        case ($urandom_range(2))
                                0: run_pair(1'b0, $urandom(), $urandom(), $urandom(), $urandom(), 1'b1);
                                1: run_pair(1'b1, $urandom(), $urandom(), $urandom(), $urandom(), 1'b1);
                                default: run_op(hw_ops[$urandom_range(7)], $urandom(), $urandom(),
                                                $urandom(), $urandom(), 1'b1, 1'b0);
                        endcase
                end

                $display("Checked results: %0d, value errors: %0d, timeouts: %0d",
                         n_checks, n_value_err, n_timeout);
                if (n_value_err == 0 && n_timeout == 0)
                begin
                        $display("NO ERRORS");
                end
                else
                begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule

//--- build.f
common/mul_pkg.sv
common/mul_operand_if.sv
common/mul_product_if.sv
design/mul_operand_select.sv
design/mul_partial_products.sv
design/mul_sequencer.sv
design/mul_unit_top.sv
verif/tb_mul_unit.sv
